//--- logic/os_pkg.sv
//--------------------------------------------------------------------------
// oversampler types and constants
// sample word layout, phase select and recovered bit pair
//--------------------------------------------------------------------------
package os_pkg;

    // bit k = first data bit at phase k, bit k+4 = second data bit at phase k
    // phases step by 45 degrees, even positions arrive inverted
    typedef logic [7:0] os_samples_t;

    typedef struct packed {
        logic       inv;      // odd bit alignment, delay the stream by one bit
        logic [1:0] sample;   // phase state code, gray ordered
    } phase_sel_t;

    typedef struct packed {
        logic first;          // earlier bit on the line
        logic second;
    } bit_pair_t;

    // even samples come from the complementary buffer leg
    localparam os_samples_t EVEN_INV_MASK = 8'h55;

    // 1 adds a half-period swap of the pair order
    localparam logic POSNEG = 1'b0;

    // phase states walk in gray order, S0..S3 pick sample index 0..3
    localparam logic [1:0] PH_S0 = 2'b00;
    localparam logic [1:0] PH_S1 = 2'b01;
    localparam logic [1:0] PH_S2 = 2'b11;
    localparam logic [1:0] PH_S3 = 2'b10;

    // zero pairs in a row before the bit-alignment tracker rearms
    // longer than any zero run inside a framed stream
    localparam logic [4:0] IDLE_PAIRS = 5'd16;

endpackage

//--- logic/link_pkg.sv
//--------------------------------------------------------------------------
// trigger link framing types and constants
//--------------------------------------------------------------------------
package link_pkg;

    // frame on the line: marker byte then payload byte, msb first
    localparam logic [7:0] MARKER_BYTE = 8'hB5;

    localparam logic [2:0] LOCK_HITS   = 3'd4;   // markers in a row to lock
    localparam logic [1:0] LOSS_MISSES = 2'd2;   // missed markers in a row to unlock

    // 16 bits per frame at 2 bits per cycle, counted 0..7
    localparam logic [2:0] FRAME_LAST_CYCLE = 3'd7;

    typedef struct packed {
        logic [7:0] data;     // payload byte, held while valid
        logic       valid;    // one-cycle strobe
    } frame_t;

endpackage

//--- logic/os_edge_detect.sv
//--------------------------------------------------------------------------
// oversampler edge detector
// registers the phase samples and flags edges between adjacent phases
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module os_edge_detect import os_pkg::*; (
    input  logic        fastclock,
    input  logic        rst_n,
    input  os_samples_t samples,
    output os_samples_t samples_fix,   // uninverted, 2 cycles after the port
    output logic [3:0]  eq4,           // edge seen between phase k and k+1
    output logic [3:0]  phase_err4     // per phase state code
);

    os_samples_t samples_q;            // first stage, still with the even inversion

    always_ff @(posedge fastclock or negedge rst_n) begin
        if (!rst_n) begin
            samples_q   <= EVEN_INV_MASK;   // same as an idle low line
            samples_fix <= '0;
            eq4         <= '0;
        end else begin
            samples_q   <= samples;
            samples_fix <= samples_q ^ EVEN_INV_MASK;   // uninvert even bits

            // neighbours come from opposite legs, so equal raw bits mean the line toggled
            eq4[0] <= (samples_q[0] == samples_q[1]) || (samples_q[4] == samples_q[5]);
            eq4[1] <= (samples_q[1] == samples_q[2]) || (samples_q[5] == samples_q[6]);
            eq4[2] <= (samples_q[2] == samples_q[3]) || (samples_q[6] == samples_q[7]);
            // wrap position, last phase of the previous bit against phase 0
            eq4[3] <= (samples_q[3] == samples_q[4]) || (samples_fix[7] == samples_q[0]);
        end
    end

    //----------------------------------------------------------------------
    // a phase is unsafe when an edge sits on either side of it
    //----------------------------------------------------------------------
    assign phase_err4[PH_S0] = eq4[3] | eq4[0];   // sample 0
    assign phase_err4[PH_S1] = eq4[0] | eq4[1];   // sample 1
    assign phase_err4[PH_S2] = eq4[1] | eq4[2];   // sample 2
    assign phase_err4[PH_S3] = eq4[2] | eq4[3];   // sample 3

    // phase machine runs off eq4 every cycle
    eq4_known: assert property (@(posedge fastclock) disable iff (!rst_n)
        !$isunknown(eq4))
        else $error("eq4 unknown after reset");

endmodule

//--- logic/os_phase_fsm.sv
//--------------------------------------------------------------------------
// oversampler phase machine
// walks the sampling phase away from edges and tracks odd bit alignment
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module os_phase_fsm import os_pkg::*; (
    input  logic       fastclock,
    input  logic       rst_n,
    input  logic [3:0] eq4,
    input  logic [1:0] pair_raw,       // {first, second} of the selected phase
    input  logic       phase_manual,
    input  phase_sel_t phase_sel_in,
    output phase_sel_t phase_sel
);

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       wrap;         // step across the bit boundary, sample 0 <-> 3
    logic       wrap_d;       // lines up with the first pair taken at the new phase
    logic       inv;
    logic       inv_base;     // inv before any wrap correction
    logic [4:0] idle_cnt;     // zero pairs in a row
    logic       armed;        // line has been idle, next one marks the frame start

    //----------------------------------------------------------------------
    // phase walk, later flag wins
    //----------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            PH_S0: begin
                if (eq4[0]) state_nxt = PH_S3;
                if (eq4[3]) state_nxt = PH_S1;
            end
            PH_S1: begin
                if (eq4[1]) state_nxt = PH_S0;
                if (eq4[0]) state_nxt = PH_S2;
            end
            PH_S2: begin
                if (eq4[1]) state_nxt = PH_S3;
                if (eq4[2]) state_nxt = PH_S1;
            end
            default: begin                        // PH_S3
                if (eq4[3]) state_nxt = PH_S2;
                if (eq4[2]) state_nxt = PH_S0;
            end
        endcase
    end

    // moving between sample 0 and 3 shifts the recovered stream by one bit
    assign wrap = !phase_manual &&
                  ((state == PH_S0 && state_nxt == PH_S3) ||
                   (state == PH_S3 && state_nxt == PH_S0));

    // first one after idle: in the first slot means even alignment
    always_comb begin
        inv_base = inv;
        if (armed && pair_raw[1])
            inv_base = 1'b0;
        else if (armed && pair_raw[0])
            inv_base = 1'b1;
    end

    always_ff @(posedge fastclock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= PH_S0;
            inv      <= 1'b0;
            wrap_d   <= 1'b0;
            idle_cnt <= '0;
            armed    <= 1'b0;
        end else begin
            if (!phase_manual)
                state <= state_nxt;               // held in manual mode
            wrap_d <= wrap;
            inv    <= inv_base ^ wrap_d;          // keeps bit parity across a wrap
            if (pair_raw != 2'b00) begin
                idle_cnt <= '0;
                armed    <= 1'b0;
            end else if (idle_cnt == IDLE_PAIRS) begin
                armed <= 1'b1;
            end else begin
                idle_cnt <= idle_cnt + 5'd1;
            end
        end
    end

    always_comb begin
        if (phase_manual) begin
            phase_sel = phase_sel_in;
        end else begin
            phase_sel.inv    = inv;
            phase_sel.sample = state;
        end
    end

    // the sampling point never jumps more than one phase
    gray_step: assert property (@(posedge fastclock) disable iff (!rst_n)
        1'b1 |=> ($countones(state ^ $past(state)) <= 1))
        else $error("phase state moved more than one gray step");

endmodule

//--- logic/os_sample_mux.sv
//--------------------------------------------------------------------------
// oversampler sample mux
// picks the selected phase and orders the recovered bit pair
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module os_sample_mux import os_pkg::*; (
    input  logic        fastclock,
    input  logic        rst_n,
    input  os_samples_t samples_fix,
    input  logic [3:0]  phase_err4,
    input  phase_sel_t  phase_sel,
    output logic [1:0]  pair_raw,      // {first, second}, no alignment applied
    output bit_pair_t   pair,
    output logic        phase_err
);

    logic [1:0] raw_sel;
    logic       second_q;              // last cycle's second bit
    logic       swap;

    always_comb begin
        case (phase_sel.sample)
            PH_S0:   raw_sel = {samples_fix[0], samples_fix[4]};   // 0 and 180 deg
            PH_S1:   raw_sel = {samples_fix[1], samples_fix[5]};   // 45 and 225 deg
            PH_S2:   raw_sel = {samples_fix[2], samples_fix[6]};   // 90 and 270 deg
            default: raw_sel = {samples_fix[3], samples_fix[7]};   // 135 and 315 deg
        endcase
    end

    always_ff @(posedge fastclock or negedge rst_n) begin
        if (!rst_n) begin
            pair_raw  <= '0;
            second_q  <= 1'b0;
            phase_err <= 1'b0;
        end else begin
            pair_raw  <= raw_sel;
            second_q  <= pair_raw[0];
            phase_err <= phase_err4[phase_sel.sample];   // err flags indexed by code
        end
    end

    // a one-bit delay is the same as sampling on the other edge, so the
    // previous second bit leads and the current first bit follows
    assign swap        = phase_sel.inv ^ POSNEG;
    assign pair.first  = swap ? second_q    : pair_raw[1];
    assign pair.second = swap ? pair_raw[1] : pair_raw[0];

endmodule

//--- logic/frame_aligner.sv
//--------------------------------------------------------------------------
// trigger link frame aligner
// hunts the marker byte, locks to the frame and strobes out payload bytes
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module frame_aligner import os_pkg::*, link_pkg::*; (
    input  logic      fastclock,
    input  logic      rst_n,
    input  bit_pair_t pair,
    output frame_t    frame,
    output logic      locked
);

    logic [15:0] win;          // last 16 line bits, newest at bit 0
    logic [2:0]  fcnt;         // cycles since the last marker
    logic [2:0]  hits;         // markers seen one frame apart
    logic [1:0]  misses;
    logic        mk_hit;
    logic        at_slot;      // next marker due this cycle
    logic [7:0]  data_q;
    logic        valid_q;

    // window moves by two bits, so every even byte offset passes win[15:8]
    // once per byte; marker in the upper byte means payload is complete below
    assign mk_hit  = (win[15:8] == MARKER_BYTE);
    assign at_slot = (fcnt == FRAME_LAST_CYCLE);

    always_ff @(posedge fastclock) begin
        win <= {win[13:0], pair.first, pair.second};   // first bit is older
        if (at_slot && mk_hit)
            data_q <= win[7:0];
    end

    //----------------------------------------------------------------------
    // hunt, lock and loss
    //----------------------------------------------------------------------
    always_ff @(posedge fastclock or negedge rst_n) begin
        if (!rst_n) begin
            fcnt    <= '0;
            hits    <= '0;
            misses  <= '0;
            locked  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            fcnt    <= fcnt + 3'd1;                  // wraps once per frame
            if (!locked) begin
                if (mk_hit) begin
                    fcnt <= '0;
                    if (at_slot && hits != '0) begin
                        hits <= hits + 3'd1;
                        if (hits + 3'd1 == LOCK_HITS) begin
                            locked <= 1'b1;
                            misses <= '0;
                        end
                    end else begin
                        hits <= 3'd1;                // new candidate offset
                    end
                end else if (at_slot) begin
                    hits <= '0;                      // expected marker missing
                end
            end else if (at_slot) begin
                if (mk_hit) begin
                    misses  <= '0;
                    valid_q <= 1'b1;
                end else if (misses == LOSS_MISSES - 2'd1) begin
                    locked <= 1'b0;
                    misses <= '0;
                    hits   <= '0;
                end else begin
                    misses <= misses + 2'd1;
                end
            end
        end
    end

    always_comb begin
        frame.data  = data_q;
        frame.valid = valid_q;
    end

    // payload strobes only come out of a locked link
    valid_needs_lock: assert property (@(posedge fastclock) disable iff (!rst_n)
        $rose(frame.valid) |-> locked)
        else $error("frame.valid rose while unlocked");

endmodule

//--- logic/sbit_link_rx.sv
//--------------------------------------------------------------------------
// trigger link receiver top
// 2x oversampler followed by the frame aligner
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module sbit_link_rx import os_pkg::*, link_pkg::*; (
    input  logic        fastclock,
    input  logic        rst_n,
    input  os_samples_t samples,        // eight phase samples per cycle
    input  logic        phase_manual,
    input  phase_sel_t  phase_sel_in,
    output phase_sel_t  phase_sel_out,
    output logic        phase_err,
    output bit_pair_t   pair,           // 3 cycles after samples
    output frame_t      frame,
    output logic        locked
);

    os_samples_t samples_fix;
    logic [3:0]  eq4;
    logic [3:0]  phase_err4;
    logic [1:0]  pair_raw;

    os_edge_detect u_edge (
        .fastclock   (fastclock),
        .rst_n       (rst_n),
        .samples     (samples),
        .samples_fix (samples_fix),
        .eq4         (eq4),
        .phase_err4  (phase_err4)
    );

    os_phase_fsm u_fsm (
        .fastclock    (fastclock),
        .rst_n        (rst_n),
        .eq4          (eq4),
        .pair_raw     (pair_raw),
        .phase_manual (phase_manual),
        .phase_sel_in (phase_sel_in),
        .phase_sel    (phase_sel_out)   // also steers the mux
    );

    os_sample_mux u_mux (
        .fastclock   (fastclock),
        .rst_n       (rst_n),
        .samples_fix (samples_fix),
        .phase_err4  (phase_err4),
        .phase_sel   (phase_sel_out),
        .pair_raw    (pair_raw),
        .pair        (pair),
        .phase_err   (phase_err)
    );

    frame_aligner u_align (
        .fastclock (fastclock),
        .rst_n     (rst_n),
        .pair      (pair),
        .frame     (frame),
        .locked    (locked)
    );

endmodule

//--- verif/sbit_link_rx_tb.sv
//--------------------------------------------------------------------------
// trigger link receiver testbench
// serial line sample model, table of link setups, payload and phase checks
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module sbit_link_rx_tb import os_pkg::*, link_pkg::*; ();

    typedef struct packed {
        logic       manual;
        phase_sel_t sel;          // used when manual is set
        logic [1:0] edge_pos;     // first phase that sees the new bit
        logic       offset;       // one extra leading bit
        logic [7:0] nframes;
        logic       loss;         // corrupt two markers mid-stream
        logic [1:0] exp_locked;   // 2 means either
        logic [1:0] exp_sample;   // phase class after settling
        logic [1:0] exp_err;      // 0 none while locked, 2 must be seen
    } row_t;

    localparam int NROWS    = 7;
    localparam int OVERHEAD = 64;          // reset, idle, burst and tail cycles per test

    row_t rows [NROWS];

    logic        fastclock;
    logic        rst_n;
    os_samples_t samples;
    logic        phase_manual;
    phase_sel_t  phase_sel_in;
    phase_sel_t  phase_sel_out;
    logic        phase_err;
    bit_pair_t   pair;
    frame_t      frame;
    logic        locked;

    logic        bits [$];                 // line bits, oldest first
    logic [7:0]  sent [$];
    logic [7:0]  got [$];
    logic        prev_bit;
    logic [1:0]  cur_edge;
    int          errors;
    int          checks;
    int          cycles;
    int          limit;
    logic        mon_on;
    logic        err_seen;
    logic        err_locked;
    logic        locked_q;
    int          lock_falls;
    int          relock_at;                // index in got of the first byte after a relock
    int          valid_unlocked;

    sbit_link_rx u_dut (
        .fastclock     (fastclock),
        .rst_n         (rst_n),
        .samples       (samples),
        .phase_manual  (phase_manual),
        .phase_sel_in  (phase_sel_in),
        .phase_sel_out (phase_sel_out),
        .phase_err     (phase_err),
        .pair          (pair),
        .frame         (frame),
        .locked        (locked)
    );

    always #5 fastclock = ~fastclock;     // 10 ns

    //----------------------------------------------------------------------
    // line model, phases below e still see the previous bit
    //----------------------------------------------------------------------
    function automatic os_samples_t line_word(input logic prv, input logic b0,
                                              input logic b1, input logic [1:0] e);
        os_samples_t w;
        for (int k = 0; k < 4; k++) begin
            w[k]   = (k < e) ? prv : b0;
            w[k+4] = (k < e) ? b0 : b1;
        end
        for (int k = 0; k < 8; k += 2) begin
            w[k] = ~w[k];                  // complementary leg
        end
        return w;
    endfunction

    task automatic push_fill(input int n, input logic v);
        for (int i = 0; i < n; i++) begin
            bits.push_back(v);
        end
    endtask

    task automatic push_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            bits.push_back(b[i]);          // msb first
        end
    endtask

    task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        assert (exp === act) else begin
            $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    // two line bits per cycle
    task automatic drive_bits(input logic idle_check, input logic auto_mode);
        logic b0;
        logic b1;
        while (bits.size() >= 2) begin
            b0 = bits.pop_front();
            b1 = bits.pop_front();
            @(posedge fastclock);
            samples <= line_word(prev_bit, b0, b1, cur_edge);
            prev_bit = b1;
            if (idle_check) begin
                @(negedge fastclock);
                check_val("locked", 8'd0, {7'd0, locked});
                check_val("frame.valid", 8'd0, {7'd0, frame.valid});
                check_val("phase_err", 8'd0, {7'd0, phase_err});
                check_val("pair", 8'd0, {6'd0, pair});   // low line recovers as zeros
                if (auto_mode)
                    check_val("phase_sel_out", 8'd0, {5'd0, phase_sel_out});
            end
        end
    endtask

    // observe outputs away from the driving edge
    always @(negedge fastclock) begin
        if (mon_on) begin
            if (frame.valid)
                got.push_back(frame.data);
            if (frame.valid && !locked)
                valid_unlocked++;
            if (phase_err)
                err_seen = 1'b1;
            if (phase_err && locked)
                err_locked = 1'b1;
            if (locked_q && !locked) begin
                lock_falls++;
                relock_at = got.size();
            end
            locked_q = locked;
        end
    end

    always @(posedge fastclock) begin
        cycles++;
        if (cycles > limit) begin
            $display("run stopped, cycle limit %0d reached", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic run_test(input row_t r, input int idx);
        int         start_err;
        int         ptr;
        logic [7:0] p;
        start_err = errors;
        bits.delete();
        sent.delete();
        got.delete();
        prev_bit = 1'b0;
        cur_edge = r.edge_pos;
        @(posedge fastclock);
        rst_n        <= 1'b0;
        phase_manual <= r.manual;
        phase_sel_in <= r.sel;
        samples      <= line_word(1'b0, 1'b0, 1'b0, r.edge_pos);   // idle low
        repeat (2) @(posedge fastclock);
        rst_n <= 1'b1;

        push_fill(16, 1'b0);
        drive_bits(1'b1, !r.manual);

        for (int i = 0; i < 16; i++) begin
            bits.push_back(i % 2 == 0);    // toggle burst lets the phase settle
        end
        push_fill(48, 1'b0);               // idle rearms the alignment tracker
        if (r.offset)
            bits.push_back(1'b0);
        for (int f = 0; f < r.nframes; f++) begin
            if (r.loss && (f == 12 || f == 13))
                push_byte(~MARKER_BYTE);
            else
                push_byte(MARKER_BYTE);
            p = 8'($urandom);
            sent.push_back(p);
            push_byte(p);
        end
        push_fill(r.offset ? 15 : 16, 1'b0);

        err_seen       = 1'b0;
        err_locked     = 1'b0;
        locked_q       = 1'b0;
        lock_falls     = 0;
        relock_at      = -1;
        valid_unlocked = 0;
        mon_on         = 1'b1;
        drive_bits(1'b0, 1'b0);
        @(negedge fastclock);
        mon_on = 1'b0;

        // ------------------------------------------------------------------
        // results of this setup
        // ------------------------------------------------------------------
        if (r.exp_locked != 2'd2)
            check_val("locked", {7'd0, r.exp_locked[0]}, {7'd0, locked});
        check_val("phase_sel_out.sample", {6'd0, r.exp_sample}, {6'd0, phase_sel_out.sample});
        if (r.manual)
            check_val("phase_sel_out", {5'd0, r.sel}, {5'd0, phase_sel_out});
        if (r.exp_err == 2'd2)
            check_true(err_seen, "phase_err never rose with the phase on the edge");
        else
            check_val("phase_err", 8'd0, {7'd0, err_locked});
        check_true(valid_unlocked == 0, "frame.valid strobed while unlocked");
        if (r.loss)
            check_true(lock_falls >= 1, "lock held through corrupted markers");
        else
            check_true(lock_falls == 0, "lock dropped on a clean stream");

        if (r.exp_locked == 2'd1) begin
            check_true(got.size() + 10 >= r.nframes, "too few payload bytes recovered");
            ptr = 0;
            foreach (got[i]) begin
                if (i == 0 || i == relock_at) begin
                    while (ptr < sent.size() - 1 && sent[ptr] != got[i])
                        ptr++;              // resync after lock or relock
                end
                checks++;
                assert (ptr < sent.size() && sent[ptr] == got[i]) else begin
                    $display("Mismatch at %0t: frame.data expected %0h got %0h",
                             $time, sent[ptr], got[i]);
                    errors++;
                end
                ptr++;
            end
        end
        $display("test %0d %s, %0d payload bytes", idx,
                 (errors == start_err) ? "ok" : "failed", got.size());
    endtask

    initial begin
        int total;
        fastclock    = 1'b0;
        rst_n        = 1'b0;
        samples      = 8'h55;
        phase_manual = 1'b0;
        phase_sel_in = '0;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        mon_on       = 1'b0;
        relock_at    = -1;
        void'($urandom(15199));

        // manual sel edge off frames loss locked sample err
        rows[0] = '{1'b0, 3'b0_00, 2'd0, 1'b0, 8'd24, 1'b0, 2'd1, PH_S1, 2'd0};
        rows[1] = '{1'b0, 3'b0_00, 2'd1, 1'b1, 8'd24, 1'b0, 2'd1, PH_S3, 2'd0};
        rows[2] = '{1'b0, 3'b0_00, 2'd2, 1'b0, 8'd24, 1'b0, 2'd1, PH_S0, 2'd0};
        rows[3] = '{1'b0, 3'b0_00, 2'd3, 1'b1, 8'd24, 1'b0, 2'd1, PH_S0, 2'd0};
        rows[4] = '{1'b1, 3'b0_11, 2'd0, 1'b0, 8'd24, 1'b0, 2'd1, PH_S2, 2'd0};
        rows[5] = '{1'b1, 3'b1_00, 2'd0, 1'b1, 8'd24, 1'b0, 2'd2, PH_S0, 2'd2};
        rows[6] = '{1'b0, 3'b0_00, 2'd2, 1'b0, 8'd32, 1'b1, 2'd1, PH_S0, 2'd0};

        total = 0;
        for (int i = 0; i < NROWS; i++) begin
            total += rows[i].nframes;
        end
        limit = total * 8 + NROWS * OVERHEAD + 200;

        for (int i = 0; i < NROWS; i++) begin
            run_test(rows[i], i);
        end

        $display("%0d tests, %0d checks, %0d errors", NROWS, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sbit_rx.f
logic/os_pkg.sv
logic/link_pkg.sv
logic/os_edge_detect.sv
logic/os_phase_fsm.sv
logic/os_sample_mux.sv
logic/frame_aligner.sv
logic/sbit_link_rx.sv
verif/sbit_link_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the trigger link receiver testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=sbit_link_rx_tb

verilator --binary --timing --assert \
    -f sbit_rx.f \
    --top-module "$TOP" \
    --Mdir obj_dir \
    -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
